/* rtl/busProtocolPkg.sv */
package busProtocolPkg;

    ////////////////////////////////////////
    // frame constants on the wire
    ////////////////////////////////////////

    localparam logic [2:0] PREAMBLE    = 3'b111;   // opens every frame
    localparam int         SLAVE_ID_W  = 3;
    localparam int         ARB_REQ_LEN = 6;        // preamble + slave id
    localparam int         CTRL_LEN    = 8;        // preamble + slave id + op

    typedef enum logic [1:0] {
        OP_READ  = 2'b00,
        OP_WRITE = 2'b01
    } ctrlOpE;

    ////////////////////////////////////////
    // control frame layout
    ////////////////////////////////////////

    typedef struct packed {
        logic [2:0]            preamble;
        logic [SLAVE_ID_W-1:0] slaveId;
        ctrlOpE                op;
    } ctrlFieldsT;

    // same word, by field or as raw bits for shifting
    typedef union packed {
        ctrlFieldsT          fields;
        logic [CTRL_LEN-1:0] bits;
    } ctrlFrameU;

endpackage

/* rtl/masterCtrlPkg.sv */
package masterCtrlPkg;

    // top level loop phases
    typedef enum logic [2:0] {
        IDLE,
        READ,
        INCR,
        WRITE,
        DONE
    } seqPhaseE;

    // strobes from sequencer to arbiter link
    typedef struct packed {
        logic request;
        logic releaseBus;
    } arbCmdT;

    // pulses back from arbiter link
    typedef struct packed {
        logic granted;
        logic released;
    } arbRspT;

    typedef struct packed {
        logic                  go;   // one cycle
        busProtocolPkg::ctrlOpE op;
    } xferCmdT;

endpackage

/* rtl/arbiterLink.sv */
`timescale 1ns/1ns

module arbiterLink
    import busProtocolPkg::*;
    import masterCtrlPkg::*;
#(
    parameter logic [SLAVE_ID_W-1:0] SLAVE_ID = 3'b100
)(
    input  logic   clk,
    input  logic   rstN,
    input  logic   arbCont,
    input  arbCmdT arbCmd,
    output arbRspT arbRsp,
    output logic   arbSend
);

    localparam int CNT_W = $clog2(ARB_REQ_LEN + 1);

    typedef enum logic [2:0] {
        A_IDLE,
        A_WAIT,
        A_REQ,
        A_GRANT,
        A_ACK,
        A_REL
    } arbStateE;

    arbStateE               state;
    logic [CNT_W-1:0]       bitCnt;
    logic [ARB_REQ_LEN-1:0] reqShift;
    logic [1:0]             grantHist;   // two latest arbCont samples

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= A_IDLE;
            bitCnt    <= '0;
            reqShift  <= '0;
            grantHist <= '0;
            arbSend   <= 1'b0;
            arbRsp    <= '0;
        end else begin
            grantHist <= {grantHist[0], arbCont};
            arbSend   <= 1'b0;   // low unless a pattern drives it
            arbRsp    <= '0;
            case (state)
                A_IDLE: begin
                    bitCnt <= '0;
                    if (arbCmd.request) begin
                        reqShift <= {PREAMBLE, SLAVE_ID};
                        state    <= A_WAIT;
                    end else if (arbCmd.releaseBus) begin
                        bitCnt <= CNT_W'(1);   // first release bit is the low default
                        state  <= A_REL;
                    end
                end
                A_WAIT: begin
                    if (!arbCont) begin   // bus quiet, start the request
                        arbSend  <= reqShift[ARB_REQ_LEN-1];
                        reqShift <= reqShift << 1;
                        bitCnt   <= bitCnt + 1'b1;
                        state    <= A_REQ;
                    end
                end
                A_REQ: begin
                    if (bitCnt == CNT_W'(ARB_REQ_LEN)) begin
                        state <= A_GRANT;
                    end else begin
                        arbSend  <= reqShift[ARB_REQ_LEN-1];
                        reqShift <= reqShift << 1;
                        bitCnt   <= bitCnt + 1'b1;
                    end
                end
                A_GRANT: begin
                    if (grantHist == 2'b11) begin
                        arbSend <= 1'b1;   // ack 1
                        bitCnt  <= CNT_W'(1);
                        state   <= A_ACK;
                    end
                end
                A_ACK: begin
                    if (bitCnt == CNT_W'(1)) begin
                        bitCnt <= CNT_W'(2);   // ack 2 stays low
                    end else begin
                        arbSend        <= 1'b1;
                        arbRsp.granted <= 1'b1;
                        state          <= A_IDLE;
                    end
                end
                A_REL: begin
                    if (bitCnt == CNT_W'(3)) begin
                        arbRsp.released <= 1'b1;
                        state           <= A_IDLE;
                    end else begin
                        arbSend <= 1'b1;
                        bitCnt  <= bitCnt + 1'b1;
                    end
                end
                default: state <= A_IDLE;
            endcase
        end
    end

endmodule

/* rtl/slaveLink.sv */
`timescale 1ns/1ns

module slaveLink
    import busProtocolPkg::*;
    import masterCtrlPkg::*;
#(
    parameter int                    DATA_WIDTH = 8,
    parameter logic [SLAVE_ID_W-1:0] SLAVE_ID   = 3'b100
)(
    input  logic                  clk,
    input  logic                  rstN,
    input  xferCmdT               xferCmd,
    input  logic [DATA_WIDTH-1:0] wrData,
    input  logic                  rD,
    input  logic                  ready,
    output logic                  control,
    output logic                  wrD,
    output logic                  valid,
    output logic                  xferDone,
    output logic [DATA_WIDTH-1:0] rdData
);

    localparam int MAX_LEN = (CTRL_LEN > DATA_WIDTH) ? CTRL_LEN : DATA_WIDTH;
    localparam int CNT_W   = $clog2(MAX_LEN + 1);

    typedef enum logic [1:0] {
        L_IDLE,
        L_CTRL,
        L_READ,
        L_WRITE
    } linkStateE;

    linkStateE           state;
    ctrlOpE              opReg;
    ctrlFrameU           frame;
    logic [CTRL_LEN-1:0] ctrlShift;
    logic [CNT_W-1:0]    bitCnt;
    logic                takeBit;

    always_comb begin
        frame.fields.preamble = PREAMBLE;
        frame.fields.slaveId  = SLAVE_ID;
        frame.fields.op       = xferCmd.op;
    end

    assign takeBit = (state == L_READ) && ready;

    ////////////////////////////////////////
    // control frame, then data bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= L_IDLE;
            opReg     <= OP_READ;
            ctrlShift <= '0;
            bitCnt    <= '0;
            control   <= 1'b0;
            wrD       <= 1'b0;
            valid     <= 1'b0;
            xferDone  <= 1'b0;
        end else begin
            control  <= 1'b0;
            xferDone <= 1'b0;
            case (state)
                L_IDLE: begin
                    if (xferCmd.go) begin
                        ctrlShift <= frame.bits;
                        opReg     <= xferCmd.op;
                        bitCnt    <= '0;
                        state     <= L_CTRL;
                    end
                end
                L_CTRL: begin
                    if (bitCnt == CNT_W'(CTRL_LEN)) begin
                        bitCnt <= '0;
                        state  <= (opReg == OP_WRITE) ? L_WRITE : L_READ;
                    end else begin
                        control   <= ctrlShift[CTRL_LEN-1];   // msb first
                        ctrlShift <= ctrlShift << 1;
                        bitCnt    <= bitCnt + 1'b1;
                    end
                end
                L_READ: begin
                    if (ready) begin   // slave paces the read
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == CNT_W'(DATA_WIDTH - 1)) begin
                            xferDone <= 1'b1;
                            state    <= L_IDLE;
                        end
                    end
                end
                L_WRITE: begin
                    if (bitCnt == CNT_W'(DATA_WIDTH)) begin
                        wrD      <= 1'b0;
                        valid    <= 1'b0;
                        xferDone <= 1'b1;
                        state    <= L_IDLE;
                    end else begin
                        wrD    <= wrData[DATA_WIDTH-1-bitCnt];
                        valid  <= 1'b1;
                        bitCnt <= bitCnt + 1'b1;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    // read word assembled msb first
    always_ff @(posedge clk) begin
        if (takeBit) begin
            rdData[DATA_WIDTH-1-bitCnt] <= rD;
        end
    end

endmodule

/* rtl/transactionSequencer.sv */
`timescale 1ns/1ns

module transactionSequencer
    import busProtocolPkg::*;
    import masterCtrlPkg::*;
#(
    parameter int DATA_WIDTH = 8
)(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic                  eoc,
    input  arbRspT                arbRsp,
    input  logic                  xferDone,
    input  logic [DATA_WIDTH-1:0] rdData,
    output arbCmdT                arbCmd,
    output xferCmdT               xferCmd,
    output logic [DATA_WIDTH-1:0] wrData,
    output logic [DATA_WIDTH-1:0] dataOut,
    output logic                  doneCom
);

    // steps of one bus transfer
    typedef enum logic [1:0] {
        S_REQ,
        S_GRANT,
        S_XFER,
        S_REL
    } stepE;

    seqPhaseE              phase;
    stepE                  step;
    logic [DATA_WIDTH-1:0] dataReg;

    assign wrData  = dataReg;
    assign dataOut = dataReg;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase   <= IDLE;
            step    <= S_REQ;
            dataReg <= '0;
            arbCmd  <= '0;
            xferCmd <= '{go: 1'b0, op: OP_READ};
            doneCom <= 1'b0;
        end else begin
            arbCmd     <= '0;
            xferCmd.go <= 1'b0;
            case (phase)
                IDLE: begin
                    step <= S_REQ;
                    if (eoc)        phase <= DONE;
                    else if (start) phase <= WRITE;
                    else            phase <= READ;
                end
                READ, WRITE: begin
                    case (step)
                        S_REQ: begin
                            arbCmd.request <= 1'b1;
                            step           <= S_GRANT;
                        end
                        S_GRANT: begin
                            if (arbRsp.granted) begin
                                xferCmd.go <= 1'b1;
                                xferCmd.op <= (phase == WRITE) ? OP_WRITE : OP_READ;
                                step       <= S_XFER;
                            end
                        end
                        S_XFER: begin
                            if (xferDone) begin
                                arbCmd.releaseBus <= 1'b1;
                                step              <= S_REL;
                            end
                        end
                        default: begin   // S_REL
                            if (arbRsp.released) begin
                                step <= S_REQ;
                                if (eoc)                 phase <= DONE;
                                else if (phase == READ)  phase <= INCR;
                                else                     phase <= READ;
                            end
                        end
                    endcase
                end
                INCR: begin
                    dataReg <= rdData + 1'b1;   // wraps at DATA_WIDTH
                    phase   <= WRITE;
                end
                DONE: doneCom <= 1'b1;   // held until reset
                default: phase <= IDLE;
            endcase
        end
    end

endmodule

/* rtl/busMaster.sv */
`timescale 1ns/1ns

module busMaster
    import busProtocolPkg::*;
    import masterCtrlPkg::*;
#(
    parameter int                    DATA_WIDTH = 8,
    parameter logic [SLAVE_ID_W-1:0] SLAVE_ID   = 3'b100
)(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  start,
    input  logic                  eoc,
    input  logic                  rD,
    input  logic                  ready,
    input  logic                  arbCont,
    output logic                  doneCom,
    output logic [DATA_WIDTH-1:0] dataOut,
    output logic                  control,
    output logic                  wrD,
    output logic                  valid,
    output logic                  arbSend
);

    arbCmdT                arbCmd;
    arbRspT                arbRsp;
    xferCmdT               xferCmd;
    logic                  xferDone;
    logic [DATA_WIDTH-1:0] wrData;
    logic [DATA_WIDTH-1:0] rdData;

    ////////////////////////////////////////
    // links to arbiter and slave
    ////////////////////////////////////////

    arbiterLink #(
        .SLAVE_ID (SLAVE_ID)
    ) arbLink0 (
        .clk     (clk),
        .rstN    (rstN),
        .arbCont (arbCont),
        .arbCmd  (arbCmd),
        .arbRsp  (arbRsp),
        .arbSend (arbSend)
    );

    slaveLink #(
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (SLAVE_ID)
    ) slvLink0 (
        .clk      (clk),
        .rstN     (rstN),
        .xferCmd  (xferCmd),
        .wrData   (wrData),
        .rD       (rD),
        .ready    (ready),
        .control  (control),
        .wrD      (wrD),
        .valid    (valid),
        .xferDone (xferDone),
        .rdData   (rdData)
    );

    transactionSequencer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) seq0 (
        .clk      (clk),
        .rstN     (rstN),
        .start    (start),
        .eoc      (eoc),
        .arbRsp   (arbRsp),
        .xferDone (xferDone),
        .rdData   (rdData),
        .arbCmd   (arbCmd),
        .xferCmd  (xferCmd),
        .wrData   (wrData),
        .dataOut  (dataOut),
        .doneCom  (doneCom)
    );

endmodule

/* verif/busMasterSva.sv */
`timescale 1ns/1ns

module busMasterSva #(
    parameter int DATA_WIDTH = 8
)(
    input logic clk,
    input logic rstN,
    input logic valid,
    input logic control,
    input logic xferDone
);

    // control frame and write data never overlap
    noOverlap: assert property (@(posedge clk) disable iff (!rstN) !(valid && control))
        else $error("valid and control high in the same cycle");

    // one write burst is exactly DATA_WIDTH bits long
    writeBurstLen: assert property (@(posedge clk) disable iff (!rstN)
        $rose(valid) |-> valid [*DATA_WIDTH] ##1 !valid)
        else $error("valid burst length differs from DATA_WIDTH");

    donePulse: assert property (@(posedge clk) disable iff (!rstN) xferDone |=> !xferDone)
        else $error("xferDone longer than one cycle");

endmodule

bind slaveLink busMasterSva #(
    .DATA_WIDTH (DATA_WIDTH)
) sva0 (
    .clk      (clk),
    .rstN     (rstN),
    .valid    (valid),
    .control  (control),
    .xferDone (xferDone)
);

/* verif/busMasterChecker.sv */
`timescale 1ns/1ns

module busMasterChecker
    import busProtocolPkg::*;
#(
    parameter int                    DATA_WIDTH = 8,
    parameter logic [SLAVE_ID_W-1:0] SLAVE_ID   = 3'b100,
    parameter int                    NUM_READS  = 4
)(
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 start,
    input  logic                                 arbSend,
    input  logic                                 arbCont,
    input  logic                                 control,
    input  logic                                 wrD,
    input  logic                                 valid,
    input  logic                                 doneCom,
    input  logic [DATA_WIDTH-1:0]                dataOut,
    input  logic [NUM_READS-1:0][DATA_WIDTH-1:0] readWords,
    output int                                   errCount
);

    typedef enum logic [2:0] {
        C_REQ,
        C_ACK,
        C_CTRL,
        C_DATA,
        C_REL
    } chkStateE;

    chkStateE              cs;
    int                    bitCnt;
    int                    readIdx;
    logic [CTRL_LEN-1:0]   shiftReg;
    ctrlFrameU             frame;
    logic                  expWrite;   // next frame should be a write
    logic [DATA_WIDTH-1:0] expWord;
    logic [DATA_WIDTH-1:0] wordReg;
    logic [DATA_WIDTH-1:0] heldOut;
    logic                  doneSeen;
    logic [2:0]            contHist;   // arbCont at the last three rising edges

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
        errCount++;
    endtask

    initial errCount = 0;

    always @(posedge clk) begin
        contHist <= {contHist[1:0], arbCont};
    end

    ////////////////////////////////////////
    // frame tracking, sampled mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstN) begin
            cs       = C_REQ;
            bitCnt   = 0;
            readIdx  = 0;
            shiftReg = '0;
            expWrite = start;   // first transfer follows start
            expWord  = '0;
            doneSeen = 1'b0;
        end else if (doneCom) begin
            if (!doneSeen) begin
                if (cs != C_REQ || bitCnt != 0)
                    reportMismatch("doneCom before release end", cs, C_REQ);
                heldOut  = dataOut;
                doneSeen = 1'b1;
            end
            if (arbSend || control || valid)
                reportMismatch("bus lines after done", {arbSend, control, valid}, 0);
            if (dataOut !== heldOut) reportMismatch("dataOut after done", dataOut, heldOut);
        end else begin
            case (cs)
                C_REQ, C_ACK: begin
                    if (control) reportMismatch("control before grant", 1, 0);
                    if (arbSend || bitCnt != 0) begin
                        shiftReg = {shiftReg[CTRL_LEN-2:0], arbSend};
                        bitCnt++;
                        // ack only after two high grant samples
                        if (cs == C_ACK && bitCnt == 1 && contHist[2:1] !== 2'b11)
                            reportMismatch("arbCont ahead of ack", contHist[2:1], 2'b11);
                    end
                    if (cs == C_REQ && bitCnt == ARB_REQ_LEN) begin
                        if (shiftReg[ARB_REQ_LEN-1:0] !== {PREAMBLE, SLAVE_ID})
                            reportMismatch("request frame", shiftReg[ARB_REQ_LEN-1:0],
                                           {PREAMBLE, SLAVE_ID});
                        bitCnt = 0;
                        cs     = C_ACK;
                    end else if (cs == C_ACK && bitCnt == 3) begin
                        if (shiftReg[2:0] !== 3'b101)
                            reportMismatch("ack pattern", shiftReg[2:0], 3'b101);
                        bitCnt = 0;
                        cs     = C_CTRL;
                    end
                end
                C_CTRL: begin
                    if (control || bitCnt != 0) begin
                        shiftReg = {shiftReg[CTRL_LEN-2:0], control};
                        bitCnt++;
                    end
                    if (bitCnt == CTRL_LEN) begin
                        frame.bits = shiftReg;
                        if (frame.fields.preamble !== PREAMBLE)
                            reportMismatch("preamble", frame.fields.preamble, PREAMBLE);
                        if (frame.fields.slaveId !== SLAVE_ID)
                            reportMismatch("slave id", frame.fields.slaveId, SLAVE_ID);
                        if (frame.fields.op !== (expWrite ? OP_WRITE : OP_READ))
                            reportMismatch("opcode", frame.fields.op,
                                           expWrite ? OP_WRITE : OP_READ);
                        if (expWrite && dataOut !== expWord)
                            reportMismatch("dataOut before write", dataOut, expWord);
                        bitCnt  = 0;
                        wordReg = '0;
                        cs      = C_DATA;
                    end
                end
                C_DATA: begin
                    if (valid) begin
                        if (!expWrite) reportMismatch("valid during read", 1, 0);
                        wordReg = {wordReg[DATA_WIDTH-2:0], wrD};
                        bitCnt++;
                    end
                    if (arbSend) begin   // first high bit of release
                        if (expWrite) begin
                            if (bitCnt != DATA_WIDTH)
                                reportMismatch("write bit count", bitCnt, DATA_WIDTH);
                            if (wordReg !== expWord)
                                reportMismatch("write word", wordReg, expWord);
                        end
                        bitCnt = 0;
                        cs     = C_REL;
                    end
                end
                C_REL: begin
                    if (bitCnt == 0) begin
                        if (!arbSend) reportMismatch("release bit 3", 0, 1);
                        bitCnt = 1;
                    end else begin
                        if (arbSend) reportMismatch("release bit 4", 1, 0);
                        if (!expWrite) begin
                            if (readIdx < NUM_READS)
                                expWord = readWords[readIdx] + DATA_WIDTH'(1);
                            readIdx++;
                            expWrite = 1'b1;
                        end else begin
                            expWrite = 1'b0;
                        end
                        bitCnt = 0;
                        cs     = C_REQ;
                    end
                end
                default: cs = C_REQ;
            endcase
        end
    end

endmodule

/* verif/busMasterTb.sv */
`timescale 1ns/1ns

module busMasterTb
    import busProtocolPkg::*;
();

    localparam int                    DATA_WIDTH = 8;
    localparam logic [SLAVE_ID_W-1:0] SLAVE_ID   = 3'b100;
    localparam int                    NUM_READS  = 4;
    localparam int                    TIMEOUT    = 200;
    localparam int                    SEL_ARB    = 0;
    localparam int                    SEL_CTRL   = 1;
    localparam int                    SEL_DONE   = 2;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] word;         // slave answer on read
        logic [3:0]            grantDelay;   // extra cycles before arbCont
        logic                  gapsOn;       // random ready gaps
    } txnEntryT;

    logic                                 clk;
    logic                                 rstN;
    logic                                 start;
    logic                                 eoc;
    logic                                 rD;
    logic                                 ready;
    logic                                 arbCont;
    logic                                 doneCom;
    logic [DATA_WIDTH-1:0]                dataOut;
    logic                                 control;
    logic                                 wrD;
    logic                                 valid;
    logic                                 arbSend;
    logic [NUM_READS-1:0][DATA_WIDTH-1:0] readWords;
    txnEntryT                             stimTable [NUM_READS];
    int                                   errCount;
    int                                   timeouts;
    int                                   seed;

    busMaster #(
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (SLAVE_ID)
    ) dut0 (
        .clk (clk), .rstN (rstN), .start (start), .eoc (eoc), .rD (rD), .ready (ready),
        .arbCont (arbCont), .doneCom (doneCom), .dataOut (dataOut), .control (control),
        .wrD (wrD), .valid (valid), .arbSend (arbSend)
    );

    busMasterChecker #(
        .DATA_WIDTH (DATA_WIDTH),
        .SLAVE_ID   (SLAVE_ID),
        .NUM_READS  (NUM_READS)
    ) chk0 (
        .clk (clk), .rstN (rstN), .start (start), .arbSend (arbSend), .control (control),
        .arbCont (arbCont), .wrD (wrD), .valid (valid), .doneCom (doneCom),
        .dataOut (dataOut), .readWords (readWords), .errCount (errCount)
    );

    always_comb begin
        for (int i = 0; i < NUM_READS; i++) readWords[i] = stimTable[i].word;
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic lineValue(input int sel);
        case (sel)
            SEL_ARB:  return arbSend;
            SEL_CTRL: return control;
            default:  return doneCom;
        endcase
    endfunction

    task automatic finishRun();
        $display("checker errors: %0d, timeouts: %0d", errCount, timeouts);
        if (errCount == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic waitForLine(input int sel, input string what);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (!lineValue(sel) && cnt < TIMEOUT);
        if (!lineValue(sel)) begin
            $display("Timeout: %s did not go high within %0d cycles", what, TIMEOUT);
            timeouts++;
            finishRun();
        end
    endtask

    ////////////////////////////////////////
    // arbiter and slave side of one transfer
    ////////////////////////////////////////

    task automatic runTransfer(input logic isRead, input txnEntryT e, input logic raiseEoc);
        int gap;
        waitForLine(SEL_ARB, "arbSend request");
        repeat (ARB_REQ_LEN - 1 + e.grantDelay) @(negedge clk);
        arbCont = 1'b1;   // grant
        waitForLine(SEL_CTRL, "control frame");
        arbCont = 1'b0;
        if (raiseEoc) eoc = 1'b1;
        if (isRead) begin
            repeat (CTRL_LEN) @(negedge clk);   // link now in read state
            for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
                gap   = e.gapsOn ? ($random(seed) & 3) : 0;
                ready = 1'b0;
                repeat (gap) @(negedge clk);
                ready = 1'b1;
                rD    = e.word[i];
                @(negedge clk);
            end
            ready = 1'b0;
            rD    = 1'b0;
        end
        waitForLine(SEL_ARB, "arbSend release");
        repeat (2) @(negedge clk);
    endtask

    initial begin
        rstN     = 1'b0;
        start    = 1'b0;
        eoc      = 1'b0;
        rD       = 1'b0;
        ready    = 1'b0;
        arbCont  = 1'b0;
        timeouts = 0;
        seed     = 32'h80fd3538;
        stimTable[0] = '{8'h3c, 4'd0, 1'b0};
        stimTable[1] = '{8'hff, 4'd3, 1'b1};   // wraps to zero
        stimTable[2] = '{8'ha5, 4'd6, 1'b1};
        stimTable[3] = '{8'h00, 4'd1, 1'b1};
        repeat (5) @(negedge clk);
        rstN = 1'b1;

        // read first, then read, increment, write loop
        for (int k = 0; k < NUM_READS; k++) begin
            runTransfer(1'b1, stimTable[k], 1'b0);
            runTransfer(1'b0, stimTable[k], k == NUM_READS - 1);
        end
        waitForLine(SEL_DONE, "doneCom");
        repeat (20) @(negedge clk);

        // second run opens with a write of zero
        rstN  = 1'b0;
        start = 1'b1;
        eoc   = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        runTransfer(1'b0, stimTable[0], 1'b1);
        waitForLine(SEL_DONE, "doneCom");
        repeat (10) @(negedge clk);
        finishRun();
    end

endmodule

/* build.f */
rtl/busProtocolPkg.sv
rtl/masterCtrlPkg.sv
rtl/arbiterLink.sv
rtl/slaveLink.sv
rtl/transactionSequencer.sv
rtl/busMaster.sv
verif/busMasterSva.sv
verif/busMasterChecker.sv
verif/busMasterTb.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/VbusMasterTb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module busMasterTb -o VbusMasterTb

run: obj_dir/VbusMasterTb
	./obj_dir/VbusMasterTb | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null

clean:
	rm -rf obj_dir
